// File: design/ppu_pkg.sv
// Shared widths, vector typedefs, demux phase enum and video-info constants

package ppu_pkg;

  // ========================================
  // Colour widths
  // ========================================

  // One colour on the N64 bus
  localparam int N64_COLOR_W = 7;
  // One colour after expansion
  localparam int OUT_COLOR_W = 8;

  typedef logic [N64_COLOR_W-1:0]   n64_color_t;
  // Red in the highest slice, blue in the lowest
  typedef logic [3*N64_COLOR_W-1:0] n64_pixel_t;
  typedef logic [3*OUT_COLOR_W-1:0] out_pixel_t;

  // ========================================
  // Sync word
  // ========================================

  // Taken from VD bits 3 to 0 in the sync phase
  typedef logic [3:0] sync_nibble_t;

  localparam int VSYNC_N_BIT = 3;
  localparam int HSYNC_N_BIT = 1;

  // ========================================
  // Video info
  // ========================================

  typedef logic [9:0] line_cnt_t;

  // Fields longer than this are PAL
  localparam int PAL_LINE_THRESHOLD = 288;

  // Resync pulse length in clocks, and the counter width that holds it
  localparam int MODE_CHANGE_CYCLES = 4;
  localparam int MODE_CNT_W         = $clog2(MODE_CHANGE_CYCLES + 1);

  // Bit 1 PAL, bit 0 interlaced
  typedef logic [1:0] ppu_state_t;

  // Phase that the next clock edge samples
  typedef enum logic [1:0] {
    PH_SYNC,
    PH_RED,
    PH_GREEN,
    PH_BLUE
  } demux_phase_e;

endpackage

// File: design/n64_bus_demux.sv
// N64 video bus demultiplexer with sync capture and pixel strobe

`timescale 1ns/1ps

module n64_bus_demux (
  input  logic                  N64_CLK_i,
  input  logic                  arst_n_i,
  input  logic                  nVDSYNC_i,
  input  ppu_pkg::n64_color_t   VD_i,
  output logic                  pix_valid_o,
  output ppu_pkg::n64_pixel_t   pix_o,
  output logic                  sync_valid_o,
  output ppu_pkg::sync_nibble_t sync_o
);

  import ppu_pkg::*;

  demux_phase_e phase_q;
  n64_color_t   red_q;
  n64_color_t   green_q;

  // ========================================
  // Phase tracking and strobes
  // ========================================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q      <= PH_SYNC;
      pix_valid_o  <= 1'b0;
      sync_valid_o <= 1'b0;
    end else begin
      pix_valid_o  <= 1'b0;
      sync_valid_o <= 1'b0;
      if (!nVDSYNC_i) begin
        // Sync phase always restarts the pixel
        sync_valid_o <= 1'b1;
        phase_q      <= PH_RED;
      end else begin
        case (phase_q)
          PH_RED:   phase_q <= PH_GREEN;
          PH_GREEN: phase_q <= PH_BLUE;
          PH_BLUE: begin
            pix_valid_o <= 1'b1;
            phase_q     <= PH_SYNC;
          end
          // No sync seen after blue, wait here without strobing
          default:  phase_q <= PH_SYNC;
        endcase
      end
    end
  end

  // ========================================
  // Data capture
  // ========================================

  always_ff @(posedge N64_CLK_i) begin
    if (!nVDSYNC_i) begin
      sync_o <= VD_i[3:0];
    end else begin
      case (phase_q)
        PH_RED:   red_q   <= VD_i;
        PH_GREEN: green_q <= VD_i;
        // Blue goes straight into the finished pixel
        PH_BLUE:  pix_o   <= {red_q, green_q, VD_i};
        default: ;
      endcase
    end
  end

endmodule

// File: design/n64_vinfo.sv
// Field line counter with PAL and interlaced detection

`timescale 1ns/1ps

module n64_vinfo (
  input  logic                  N64_CLK_i,
  input  logic                  arst_n_i,
  input  logic                  sync_valid_i,
  input  ppu_pkg::sync_nibble_t sync_i,
  output logic                  pal_o,
  output logic                  interlaced_o
);

  import ppu_pkg::*;

  sync_nibble_t sync_q;
  line_cnt_t    line_cnt_q;
  logic         last_parity_q;
  logic         first_vs_seen_q;
  logic         hs_fall;
  logic         vs_fall;

  // Both syncs are active low, so a fall marks the start of the pulse
  assign hs_fall = sync_valid_i & sync_q[HSYNC_N_BIT] & ~sync_i[HSYNC_N_BIT];
  assign vs_fall = sync_valid_i & sync_q[VSYNC_N_BIT] & ~sync_i[VSYNC_N_BIT];

  // ========================================
  // Previous sync word
  // ========================================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // Idle level of both syncs is high
      sync_q <= '1;
    end else if (sync_valid_i) begin
      sync_q <= sync_i;
    end
  end

  // ========================================
  // Line count and field evaluation
  // ========================================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      line_cnt_q      <= '0;
      last_parity_q   <= 1'b0;
      first_vs_seen_q <= 1'b0;
      pal_o           <= 1'b0;
      interlaced_o    <= 1'b0;
    end else if (vs_fall) begin
      // First field after reset is partial, only its parity is kept
      if (first_vs_seen_q) begin
        pal_o        <= (line_cnt_q > line_cnt_t'(PAL_LINE_THRESHOLD));
        interlaced_o <= (line_cnt_q[0] != last_parity_q);
      end
      last_parity_q   <= line_cnt_q[0];
      first_vs_seen_q <= 1'b1;
      line_cnt_q      <= '0;
    end else if (hs_fall) begin
      line_cnt_q <= line_cnt_q + 1'b1;
    end
  end

endmodule

// File: design/color_proc.sv
// Two-stage colour pipeline with 16-bit masking and 7-to-8-bit expansion

`timescale 1ns/1ps

module color_proc (
  input  logic                  N64_CLK_i,
  input  logic                  arst_n_i,
  input  logic                  color_16bit_i,
  input  logic                  pix_valid_i,
  input  ppu_pkg::n64_pixel_t   pix_i,
  input  ppu_pkg::sync_nibble_t sync_i,
  output logic                  out_valid_o,
  output ppu_pkg::out_pixel_t   out_pix_o,
  output ppu_pkg::sync_nibble_t out_sync_o
);

  import ppu_pkg::*;

  n64_color_t   col_mask;
  n64_pixel_t   masked_pix;
  out_pixel_t   expanded_pix;
  logic         s1_valid_q;
  n64_pixel_t   s1_pix_q;
  sync_nibble_t s1_sync_q;

  // 16-bit mode drops the two lowest bits of each colour
  assign col_mask = color_16bit_i ? {{(N64_COLOR_W-2){1'b1}}, 2'b00} : '1;

  always_comb begin
    for (int c = 0; c < 3; c++) begin
      masked_pix[c*N64_COLOR_W +: N64_COLOR_W] =
        pix_i[c*N64_COLOR_W +: N64_COLOR_W] & col_mask;
    end
  end

  // Replicate the top bit as new LSB so full scale stays full scale
  always_comb begin
    for (int c = 0; c < 3; c++) begin
      expanded_pix[c*OUT_COLOR_W +: OUT_COLOR_W] =
        {s1_pix_q[c*N64_COLOR_W +: N64_COLOR_W], s1_pix_q[c*N64_COLOR_W + N64_COLOR_W-1]};
    end
  end

  // ========================================
  // Valid pipe
  // ========================================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid_q  <= 1'b0;
      out_valid_o <= 1'b0;
    end else begin
      s1_valid_q  <= pix_valid_i;
      out_valid_o <= s1_valid_q;
    end
  end

  // Data only moves with its valid, so it holds between pixels
  always_ff @(posedge N64_CLK_i) begin
    if (pix_valid_i) begin
      s1_pix_q  <= masked_pix;
      s1_sync_q <= sync_i;
    end
    if (s1_valid_q) begin
      out_pix_o  <= expanded_pix;
      out_sync_o <= s1_sync_q;
    end
  end

endmodule

// File: design/pixel_output.sv
// Output register, sync polarity, state word and mode-change resync pulse

`timescale 1ns/1ps

module pixel_output (
  input  logic                  N64_CLK_i,
  input  logic                  arst_n_i,
  input  logic                  valid_i,
  input  ppu_pkg::out_pixel_t   pix_i,
  input  ppu_pkg::sync_nibble_t sync_i,
  input  logic                  pal_i,
  input  logic                  interlaced_i,
  output logic                  DE_o,
  output logic                  HSYNC_o,
  output logic                  VSYNC_o,
  output ppu_pkg::out_pixel_t   VD_o,
  output ppu_pkg::ppu_state_t   ppu_state_o,
  output logic                  mode_change_o
);

  import ppu_pkg::*;

  logic                  pal_q;
  logic [MODE_CNT_W-1:0] mc_cnt_q;

  // ========================================
  // Video outputs
  // ========================================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      DE_o    <= 1'b0;
      HSYNC_o <= 1'b0;
      VSYNC_o <= 1'b0;
      VD_o    <= '0;
    end else begin
      DE_o <= valid_i;
      if (valid_i) begin
        VD_o    <= pix_i;
        // Bus syncs are active low, outputs active high
        HSYNC_o <= ~sync_i[HSYNC_N_BIT];
        VSYNC_o <= ~sync_i[VSYNC_N_BIT];
      end
    end
  end

  // ========================================
  // State word and resync pulse
  // ========================================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ppu_state_o <= '0;
      pal_q       <= 1'b0;
      mc_cnt_q    <= '0;
    end else begin
      ppu_state_o <= {pal_i, interlaced_i};
      pal_q       <= pal_i;
      if (pal_q != pal_i) begin
        mc_cnt_q <= MODE_CNT_W'(MODE_CHANGE_CYCLES);
      end else if (mc_cnt_q != '0) begin
        mc_cnt_q <= mc_cnt_q - 1'b1;
      end
    end
  end

  assign mode_change_o = (mc_cnt_q != '0);

endmodule

// File: design/n64_ppu_top.sv
// N64 input post-processing top level with demux, video info, colour and output stages

`timescale 1ns/1ps

module n64_ppu_top (
  input  logic                N64_CLK_i,
  input  logic                arst_n_i,
  input  logic                nVDSYNC_i,
  input  ppu_pkg::n64_color_t VD_i,
  input  logic                color_16bit_i,
  output logic                DE_o,
  output logic                HSYNC_o,
  output logic                VSYNC_o,
  output ppu_pkg::out_pixel_t VD_o,
  output ppu_pkg::ppu_state_t ppu_state_o,
  output logic                mode_change_o
);

  logic                  pix_valid_w;
  ppu_pkg::n64_pixel_t   pix_w;
  logic                  sync_valid_w;
  ppu_pkg::sync_nibble_t sync_w;
  logic                  pal_w;
  logic                  interlaced_w;
  logic                  col_valid_w;
  ppu_pkg::out_pixel_t   col_pix_w;
  ppu_pkg::sync_nibble_t col_sync_w;

  // ========================================
  // Decode
  // ========================================

  n64_bus_demux n64_bus_demux_inst (
    .N64_CLK_i    (N64_CLK_i),
    .arst_n_i     (arst_n_i),
    .nVDSYNC_i    (nVDSYNC_i),
    .VD_i         (VD_i),
    .pix_valid_o  (pix_valid_w),
    .pix_o        (pix_w),
    .sync_valid_o (sync_valid_w),
    .sync_o       (sync_w)
  );

  n64_vinfo n64_vinfo_inst (
    .N64_CLK_i    (N64_CLK_i),
    .arst_n_i     (arst_n_i),
    .sync_valid_i (sync_valid_w),
    .sync_i       (sync_w),
    .pal_o        (pal_w),
    .interlaced_o (interlaced_w)
  );

  // ========================================
  // Colour and output
  // ========================================

  color_proc color_proc_inst (
    .N64_CLK_i     (N64_CLK_i),
    .arst_n_i      (arst_n_i),
    .color_16bit_i (color_16bit_i),
    .pix_valid_i   (pix_valid_w),
    .pix_i         (pix_w),
    .sync_i        (sync_w),
    .out_valid_o   (col_valid_w),
    .out_pix_o     (col_pix_w),
    .out_sync_o    (col_sync_w)
  );

  pixel_output pixel_output_inst (
    .N64_CLK_i     (N64_CLK_i),
    .arst_n_i      (arst_n_i),
    .valid_i       (col_valid_w),
    .pix_i         (col_pix_w),
    .sync_i        (col_sync_w),
    .pal_i         (pal_w),
    .interlaced_i  (interlaced_w),
    .DE_o          (DE_o),
    .HSYNC_o       (HSYNC_o),
    .VSYNC_o       (VSYNC_o),
    .VD_o          (VD_o),
    .ppu_state_o   (ppu_state_o),
    .mode_change_o (mode_change_o)
  );

endmodule

// File: tb/n64_ppu_properties.sv
// Concurrent output checks for the N64 PPU and their bind to the top level

`timescale 1ns/1ps

module n64_ppu_properties (
  input  logic                N64_CLK_i,
  input  logic                arst_n_i,
  input  logic                DE_i,
  input  logic                HSYNC_i,
  input  logic                VSYNC_i,
  input  ppu_pkg::out_pixel_t out_pix_i,
  input  ppu_pkg::ppu_state_t ppu_state_i,
  input  logic                mode_change_i
);

  import ppu_pkg::*;

  // Failure tallies, one per property
  int unsigned de_fail_cnt    = 0;
  int unsigned pulse_fail_cnt = 0;
  int unsigned reset_fail_cnt = 0;
  int unsigned lsb_fail_cnt   = 0;

  // One strobe per pixel, never two in a row
  de_single_cycle: assert property (@(posedge N64_CLK_i) disable iff (!arst_n_i)
    DE_i |=> !DE_i)
    else begin
      de_fail_cnt++;
      $error("DE_o stayed high for two consecutive cycles");
    end

  // Counted back from the end of the pulse
  pulse_length: assert property (@(posedge N64_CLK_i) disable iff (!arst_n_i)
    $fell(mode_change_i) |->
      $past(mode_change_i, MODE_CHANGE_CYCLES) && !$past(mode_change_i, MODE_CHANGE_CYCLES + 1))
    else begin
      pulse_fail_cnt++;
      $error("mode_change_o pulse length differs from MODE_CHANGE_CYCLES");
    end

  reset_outputs_low: assert property (@(posedge N64_CLK_i)
    !arst_n_i |-> !DE_i && !HSYNC_i && !VSYNC_i && out_pix_i == '0 &&
                  ppu_state_i == '0 && !mode_change_i)
    else begin
      reset_fail_cnt++;
      $error("An output is not low while reset is asserted");
    end

  // Expansion copies each colour's top bit into its new LSB
  lsb_replicates_msb: assert property (@(posedge N64_CLK_i) disable iff (!arst_n_i)
    DE_i |-> out_pix_i[0] == out_pix_i[OUT_COLOR_W-1] &&
             out_pix_i[OUT_COLOR_W] == out_pix_i[2*OUT_COLOR_W-1] &&
             out_pix_i[2*OUT_COLOR_W] == out_pix_i[3*OUT_COLOR_W-1])
    else begin
      lsb_fail_cnt++;
      $error("Output colour LSB does not match its MSB");
    end

endmodule

bind n64_ppu_top n64_ppu_properties n64_ppu_properties_inst (
  .N64_CLK_i     (N64_CLK_i),
  .arst_n_i      (arst_n_i),
  .DE_i          (DE_o),
  .HSYNC_i       (HSYNC_o),
  .VSYNC_i       (VSYNC_o),
  .out_pix_i     (VD_o),
  .ppu_state_i   (ppu_state_o),
  .mode_change_i (mode_change_o)
);

// File: tb/n64_ppu_tb.sv
// Testbench for the N64 PPU with bus stimulus, field generator, reference queue and report

`timescale 1ns/1ps

module n64_ppu_tb;

  import ppu_pkg::*;

  // Lines sent by the field tests, each line two pixels of four clocks
  localparam int FIELD_LINES = 5 * 262 + 2 * 312 + 263 + 1;
  localparam int CYCLE_LIMIT = (FIELD_LINES * 2 + 64) * 4 + 1000;

  logic         n64_clk = 1'b0;
  logic         arst_n;
  logic         nvdsync;
  n64_color_t   vd_in;
  logic         color_16bit;
  logic         de;
  logic         hsync;
  logic         vsync;
  out_pixel_t   vd_out;
  ppu_state_t   ppu_state;
  logic         mode_change;

  int           cyc = 0;
  int           checks = 0;
  int           errors = 0;
  int           mc_high = 0;
  logic [31:0]  rng = 32'd54;
  // Expected pixel, {VSYNC_o, HSYNC_o} and the cycle of its DE_o
  out_pixel_t   exp_pix_q[$];
  logic [1:0]   exp_sync_q[$];
  int           exp_due_q[$];

  n64_ppu_top n64_ppu_top_inst (
    .N64_CLK_i     (n64_clk),
    .arst_n_i      (arst_n),
    .nVDSYNC_i     (nvdsync),
    .VD_i          (vd_in),
    .color_16bit_i (color_16bit),
    .DE_o          (de),
    .HSYNC_o       (hsync),
    .VSYNC_o       (vsync),
    .VD_o          (vd_out),
    .ppu_state_o   (ppu_state),
    .mode_change_o (mode_change)
  );

  always #4 n64_clk = ~n64_clk;

  // Cycle count and run limit
  always @(posedge n64_clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Finished with errors");
      $finish;
    end
  end

  // ========================================
  // Reference model
  // ========================================

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // 16-bit mode drops two LSBs, then the top bit fills the new LSB
  function automatic logic [OUT_COLOR_W-1:0] widen(input n64_color_t c, input logic mode16);
    n64_color_t m;
    m = mode16 ? (c >> 2) << 2 : c;
    return {m, 1'b0} | OUT_COLOR_W'(m >> (N64_COLOR_W - 1));
  endfunction

  task automatic send_pixel(input sync_nibble_t sync);
    n64_color_t col[3];
    rng = xorshift32(rng);
    col[0] = rng[6:0];
    col[1] = rng[13:7];
    col[2] = rng[20:14];
    @(posedge n64_clk);
    #1;
    nvdsync = 1'b0;
    vd_in   = {3'b000, sync};
    for (int i = 0; i < 3; i++) begin
      @(posedge n64_clk);
      #1;
      nvdsync = 1'b1;
      vd_in   = col[i];
    end
    exp_pix_q.push_back({widen(col[0], color_16bit), widen(col[1], color_16bit),
                         widen(col[2], color_16bit)});
    exp_sync_q.push_back({~sync[VSYNC_N_BIT], ~sync[HSYNC_N_BIT]});
    // Blue is sampled on the next edge, DE_o follows three edges later
    exp_due_q.push_back(cyc + 4);
  endtask

  // Hsync low on each line's first pixel, vsync low on the first line's second pixel
  task automatic send_field(input int lines);
    for (int l = 0; l < lines; l++) begin
      send_pixel(4'b1101);
      send_pixel(l == 0 ? 4'b0111 : 4'b1111);
    end
  endtask

  task automatic check_state(input ppu_state_t expected, input string what);
    checks++;
    assert (ppu_state == expected) else begin
      $display("mismatch at %0t: %s, ppu_state_o %b, expected %b",
               $time, what, ppu_state, expected);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    while (exp_pix_q.size() != 0) @(negedge n64_clk);
    @(posedge n64_clk);
    #1;
    $display("Test %s done, %0d errors", name, errors - errors_before);
  endtask

  // ========================================
  // Output compare
  // ========================================

  always @(negedge n64_clk) begin
    if (mode_change) mc_high++;
    if (arst_n && de) begin
      if (exp_pix_q.size() == 0) begin
        $display("DE_o at %0t for a pixel that was never sent", $time);
        errors++;
      end else begin
        checks++;
        assert (vd_out == exp_pix_q[0] && {vsync, hsync} == exp_sync_q[0]) else begin
          $display("mismatch at %0t: VD_o %h syncs %b, expected %h syncs %b",
                   $time, vd_out, {vsync, hsync}, exp_pix_q[0], exp_sync_q[0]);
          errors++;
        end
        assert (cyc == exp_due_q[0]) else begin
          $display("mismatch at %0t: DE_o in cycle %0d, expected cycle %0d",
                   $time, cyc, exp_due_q[0]);
          errors++;
        end
        void'(exp_pix_q.pop_front());
        void'(exp_sync_q.pop_front());
        void'(exp_due_q.pop_front());
      end
    end
  end

  // ========================================
  // Test sequence
  // ========================================

  initial begin
    int mark;
    int prop_errors;
    arst_n      = 1'b0;
    nvdsync     = 1'b1;
    vd_in       = '0;
    color_16bit = 1'b0;
    repeat (2) @(posedge n64_clk);
    #1;
    arst_n = 1'b1;

    mark = errors;
    repeat (16) send_pixel(4'b1111);
    finish_test("pixel_path", mark);

    mark = errors;
    color_16bit = 1'b1;
    repeat (16) send_pixel(4'b1111);
    finish_test("color_16bit", mark);
    color_16bit = 1'b0;

    mark = errors;
    send_pixel(4'b1101);
    send_pixel(4'b0111);
    send_pixel(4'b0101);
    send_pixel(4'b1111);
    finish_test("sync_polarity", mark);

    mark = errors;
    repeat (2) send_field(262);
    check_state(2'b00, "after NTSC fields");
    mc_high = 0;
    repeat (2) send_field(312);
    check_state(2'b10, "after PAL fields");
    checks++;
    assert (mc_high == MODE_CHANGE_CYCLES) else begin
      $display("mismatch at %0t: resync pulse high for %0d cycles, expected %0d",
               $time, mc_high, MODE_CHANGE_CYCLES);
      errors++;
    end
    finish_test("pal_detect", mark);

    mark = errors;
    send_field(262);
    send_field(263);
    send_field(262);
    check_state(2'b01, "after alternating fields");
    send_field(262);
    // Short field whose vsync closes the second equal field
    send_field(1);
    check_state(2'b00, "after equal fields");
    finish_test("interlace_detect", mark);

    prop_errors = n64_ppu_top_inst.n64_ppu_properties_inst.de_fail_cnt +
                  n64_ppu_top_inst.n64_ppu_properties_inst.pulse_fail_cnt +
                  n64_ppu_top_inst.n64_ppu_properties_inst.reset_fail_cnt +
                  n64_ppu_top_inst.n64_ppu_properties_inst.lsb_fail_cnt;
    $display("Summary: %0d checks, %0d check errors, %0d assertion failures",
             checks, errors, prop_errors);
    if (errors == 0 && prop_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: n64_ppu.f
design/ppu_pkg.sv
design/n64_bus_demux.sv
design/n64_vinfo.sv
design/color_proc.sv
design/pixel_output.sv
design/n64_ppu_top.sv
tb/n64_ppu_properties.sv
tb/n64_ppu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the N64 PPU testbench with Verilator, run it and search the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module n64_ppu_tb \
  -f n64_ppu.f -o n64_ppu_sim \
  && ./obj_dir/n64_ppu_sim +verilator+error+limit+1000 | tee sim.log \
  || { echo "Verilator build or run failed"; exit 1; }

grep -qx "Finished with no errors" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
